//--- sim.f
+incdir+.
rv_isa_pkg.sv
rv_core_pkg.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
rv_core_top.sv
tb_apb_mem.sv
tb_rv_core.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_rv_core -o tb_rv_core_sim
out=$(./obj_dir/tb_rv_core_sim)
echo "$out"

if echo "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1

//--- tb_rv_core.sv
`default_nettype none

`include "rv_config.svh"

module tb_rv_core;

    localparam logic [63:0] MARKER_ADDR = 64'h7F8;  // Handler store slot
    localparam logic [63:0] HANDLER_PC  = `TRAP_VECTOR;
    localparam int          NUM_GROUPS  = 16;

    logic        clk = 1'b0;
    logic        reset = 1'b0;
    logic        irq = 1'b0;
    logic [63:0] pc;
    logic [31:0] instruction;
    logic        interrupt_ack;
    logic [63:0] paddr;
    logic [63:0] pwdata;
    logic        pwrite;
    logic        psel;
    logic        penable;
    logic [63:0] prdata;
    logic        pready;
    logic        log_valid;
    logic [63:0] log_addr;
    logic [63:0] log_data;

    logic [31:0] imem [1024];  // Word per pc offset from RAM_BASE
    logic [63:0] exp_addr [$];
    logic [63:0] exp_data [$];
    int          exp_test [$];
    logic [63:0] marker_exp;
    logic [63:0] hold_addr;
    logic [63:0] hold_data;
    string       test_name [5] = '{"reset", "alu", "jal", "ldsd", "irq"};
    int          errs [5] = '{0, 0, 0, 0, 0};
    int          checks = 0;
    int          n = 0;  // Next free instruction slot
    int          exp_idx = 0;
    int          marker_count = 0;
    int          ack_count = 0;
    int          run_cycles = 0;
    int          irq_cycle = 0;
    int          timeout_limit = 1000000;
    bit          irq_sent = 1'b0;

    always #10 clk = ~clk;

    // Instruction memory reads in the same cycle as pc
    assign instruction = imem[pc[11:2]];

    rv_core_top rv_core_top_inst (
        .clk(clk), .reset(reset), .pc(pc), .instruction(instruction), .irq(irq),
        .interrupt_ack(interrupt_ack), .paddr(paddr), .pwdata(pwdata), .pwrite(pwrite),
        .psel(psel), .penable(penable), .prdata(prdata), .pready(pready)
    );

    tb_apb_mem apb_mem (
        .clk(clk), .reset(reset), .paddr(paddr), .pwdata(pwdata), .pwrite(pwrite),
        .psel(psel), .penable(penable), .prdata(prdata), .pready(pready),
        .log_valid(log_valid), .log_addr(log_addr), .log_data(log_data)
    );

    // RV64 encoders
    function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, rv_isa_pkg::OP_LUI};
    endfunction

    function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, rv_isa_pkg::OP_IMM};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_isa_pkg::OP_JAL};
    endfunction

    function automatic logic [31:0] enc_ld(input logic [4:0] rd, input logic [11:0] imm);
        return {imm, 5'd0, rv_isa_pkg::F3_DOUBLE, rd, rv_isa_pkg::OP_LOAD};  // Base x0
    endfunction

    function automatic logic [31:0] enc_sd(input logic [4:0] rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, 5'd0, rv_isa_pkg::F3_DOUBLE, imm[4:0], rv_isa_pkg::OP_STORE};
    endfunction

    task automatic emit(input logic [31:0] w);
        imem[10'(n)] = w;
        n++;
    endtask

    // ISA-order model of the main program, fills the expected store list
    function automatic void run_reference();
        logic [63:0] r [`NUM_REGS];
        int          tag [`NUM_REGS];  // Test that last wrote the register
        logic [63:0] rmem [logic [63:0]];
        logic [63:0] rpc;
        logic [63:0] ea;
        logic [63:0] immj;
        logic [31:0] w;
        int          steps;
        bit          done;
        for (int i = 0; i < `NUM_REGS; i++) begin
            r[i]   = 64'd0;
            tag[i] = 1;
        end
        rpc   = `RAM_BASE;
        steps = 0;
        done  = 1'b0;
        while (!done && steps < 4096) begin
            w = imem[rpc[11:2]];
            steps++;
            case (w[6:0])
                rv_isa_pkg::OP_LUI: begin
                    r[w[11:7]]   = {{32{w[31]}}, w[31:12], 12'h000};
                    tag[w[11:7]] = 1;
                end
                rv_isa_pkg::OP_IMM: begin
                    r[w[11:7]]   = r[w[19:15]] + {{52{w[31]}}, w[31:20]};
                    tag[w[11:7]] = 1;
                end
                rv_isa_pkg::OP_JAL: begin
                    immj = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                    done = (immj == 64'd0);  // Self loop ends the program
                    r[w[11:7]]   = rpc + 64'd4;
                    tag[w[11:7]] = 2;
                end
                rv_isa_pkg::OP_LOAD: begin
                    ea = r[w[19:15]] + {{52{w[31]}}, w[31:20]};
                    r[w[11:7]]   = rmem[ea];
                    tag[w[11:7]] = 3;
                end
                rv_isa_pkg::OP_STORE: begin
                    ea = r[w[19:15]] + {{52{w[31]}}, w[31:25], w[11:7]};
                    rmem[ea] = r[w[24:20]];
                    exp_addr.push_back(ea);
                    exp_data.push_back(r[w[24:20]]);
                    exp_test.push_back(tag[w[24:20]]);
                end
                default: ;
            endcase
            r[0] = 64'd0;  // x0 stays zero
            rpc = (w[6:0] == rv_isa_pkg::OP_JAL) ? rpc + immj : rpc + 64'd4;
        end
        marker_exp = r[31];
    endfunction

    task automatic check_value(input int test, input logic [63:0] expv, input logic [63:0] act);
        checks++;
        assert (act === expv) else begin
            errs[test]++;
            $display("Mismatch test=%s expected=%h actual=%h", test_name[test], expv, act);
        end
    endtask

    task automatic report_test(input int test);
        $display("%s: %s (%0d errors)", test_name[test], (errs[test] == 0) ? "ok" : "failed",
                 errs[test]);
    endtask

    // Build the program
    initial begin
        logic [4:0]  rd;
        logic [11:0] off;
        int          kind;
        int          nstore;
        logic [11:0] stored [$];
        void'($urandom(32'h5427));
        nstore = 0;
        for (int i = 0; i < 1024; i++) begin
            imem[i] = enc_addi(5'd0, 5'd0, 12'(i));  // nop fill, immediate tags the slot
        end
        emit(enc_lui(5'd31, 20'($urandom)));  // Handler marker
        for (int i = 1; i < 31; i++) begin
            emit(enc_addi(5'(i), 5'd0, 12'($urandom)));  // No X in the register file
        end
        for (int g = 0; g < NUM_GROUPS; g++) begin
            kind = (g < 4) ? (g + 1) % 4 : int'($urandom_range(3, 0));  // Early groups hit every kind
            rd   = 5'($urandom_range(30, 1));
            if (kind == 3 && stored.size() == 0) begin
                kind = 0;
            end
            case (kind)
                0: emit(enc_lui(rd, 20'($urandom)));
                1: begin
                    if (g % 5 == 0) begin
                        rd = 5'd0;  // Write to x0 must be dropped
                    end
                    emit(enc_addi(rd, 5'($urandom), 12'($urandom)));
                end
                2: begin
                    emit(enc_jal(rd, 21'd12));
                    emit(enc_sd(rd, 12'h700));  // Skipped block
                    emit(enc_sd(5'd31, 12'h708));
                end
                default: emit(enc_ld(rd, stored[$urandom_range(stored.size() - 1, 0)]));
            endcase
            off = 12'(8 * nstore);
            emit(enc_sd(rd, off));
            stored.push_back(off);
            nstore++;
        end
        emit(enc_jal(5'd0, 21'd0));
        timeout_limit = 40 * n;
        irq_cycle     = int'($urandom_range(n, 3));
        imem[HANDLER_PC[11:2]] = enc_sd(5'd31, MARKER_ADDR[11:0]);
        imem[HANDLER_PC[11:2] + 10'd1] = rv_isa_pkg::MRET_WORD;
        run_reference();
    end

    // Reset phase and end of run
    initial begin
        repeat (5) begin
            @(negedge clk);
            check_value(0, `RAM_BASE, pc);
            check_value(0, 64'd0, {60'd0, pwrite, psel, penable, interrupt_ack});
        end
        @(posedge clk);
        reset <= 1'b1;
        report_test(0);
        while (exp_idx < exp_addr.size() || marker_count == 0) begin
            @(posedge clk);
        end
        repeat (30) @(posedge clk);  // Catch late extra stores
        checks++;
        assert (ack_count == 1) else begin
            errs[4]++;
            $display("interrupt_ack pulsed %0d times instead of once", ack_count);
        end
        checks++;
        assert (marker_count == 1) else begin
            errs[4]++;
            $display("Handler marker stored %0d times instead of once", marker_count);
        end
        for (int t = 1; t < 5; t++) begin
            report_test(t);
        end
        $display("Checks: %0d run, %0d failed", checks,
                 errs[0] + errs[1] + errs[2] + errs[3] + errs[4]);
        if (errs[0] + errs[1] + errs[2] + errs[3] + errs[4] == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Store compare against the reference list
    always @(posedge clk) begin
        if (log_valid) begin
            if (log_addr == MARKER_ADDR) begin
                marker_count++;
                check_value(4, marker_exp, log_data);
            end else begin
                checks++;
                assert (exp_idx < exp_addr.size()) else begin
                    errs[(log_addr >= 64'h700) ? 2 : 3]++;
                    $display("Unexpected store of %h to address %h", log_data, log_addr);
                end
                if (exp_idx < exp_addr.size()) begin
                    check_value(exp_test[exp_idx], exp_addr[exp_idx], log_addr);
                    check_value(exp_test[exp_idx], exp_data[exp_idx], log_data);
                    exp_idx++;
                end
            end
        end
    end

    // APB address and data held from setup to pready
    always @(posedge clk) begin
        if (psel && !penable) begin
            hold_addr <= paddr;
            hold_data <= pwdata;
        end else if (psel && penable) begin
            check_value(3, hold_addr, paddr);
            check_value(3, hold_data, pwdata);
        end
    end

    // Interrupt line, raised once and dropped on acknowledge
    always @(posedge clk) begin
        if (reset) begin
            run_cycles <= run_cycles + 1;
            if (interrupt_ack) begin
                ack_count++;
                irq <= 1'b0;
            end else if (!irq_sent && run_cycles == irq_cycle) begin
                irq      <= 1'b1;
                irq_sent = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        if (run_cycles >= timeout_limit) begin
            $display("Timeout after %0d cycles, the program did not finish", run_cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tb_apb_mem.sv
`default_nettype none

module tb_apb_mem (
    input  wire         clk,
    input  wire         reset,
    input  wire  [63:0] paddr,
    input  wire  [63:0] pwdata,
    input  wire         pwrite,
    input  wire         psel,
    input  wire         penable,
    output logic [63:0] prdata = 64'd0,
    output logic        pready = 1'b0,
    output logic        log_valid = 1'b0,  // One pulse per completed write
    output logic [63:0] log_addr = 64'd0,
    output logic [63:0] log_data = 64'd0
);

    logic [63:0] mem [logic [63:0]];  // Sparse doubleword store
    int          waits;
    int          pick;

    always @(posedge clk or negedge reset) begin
        if (!reset) begin
            pready    <= 1'b0;
            log_valid <= 1'b0;
            waits     <= 0;
        end else begin
            log_valid <= 1'b0;
            if (psel && !penable) begin  // Setup cycle seen
                pick   = int'($urandom_range(3, 0));
                waits  <= pick;
                pready <= (pick == 0);
                // Unwritten words read back a pattern of the full address
                prdata <= mem.exists(paddr) ? mem[paddr] : (paddr ^ 64'hC3A5_5A3C_0F1E_E1F0);
            end else if (psel && penable && !pready) begin
                if (waits == 1) begin
                    pready <= 1'b1;
                end
                waits <= waits - 1;
            end else if (psel && penable && pready) begin  // Transfer completes
                pready <= 1'b0;
                if (pwrite) begin
                    mem[paddr] = pwdata;
                    log_valid <= 1'b1;
                    log_addr  <= paddr;
                    log_data  <= pwdata;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rv_core_top.sv
`default_nettype none

module rv_core_top (
    input  wire         clk,
    input  wire         reset,
    output logic [63:0] pc,
    input  wire  [31:0] instruction,
    input  wire         irq,
    output logic        interrupt_ack,
    output logic [63:0] paddr,
    output logic [63:0] pwdata,
    output logic        pwrite,
    output logic        psel,
    output logic        penable,
    input  wire  [63:0] prdata,
    input  wire         pready
);

    // Decode outputs
    rv_core_pkg::uop_t d_uop;
    logic [4:0]  d_rd;
    logic [4:0]  d_rs1;
    logic [4:0]  d_rs2;
    logic [63:0] d_imm;
    logic [63:0] d_instr_pc;
    logic        d_valid;

    // Pipeline control
    logic stall;
    logic flush;

    // Write-back and trap handshake
    logic        wb_en;
    logic [4:0]  wb_rd;
    logic [63:0] wb_data;
    logic        trap_take;
    logic        mret_take;

    logic [63:0] rs1_data;
    logic [63:0] rs2_data;
    logic [63:0] mepc;
    logic        mie_bit;

    rv_decode u_decode (
        .clk(clk), .reset(reset), .instruction(instruction), .pc(pc),
        .stall(stall), .flush(flush), .uop(d_uop), .rd(d_rd), .rs1(d_rs1),
        .rs2(d_rs2), .imm(d_imm), .instr_pc(d_instr_pc), .valid(d_valid)
    );

    rv_execute u_execute (
        .clk(clk), .reset(reset), .uop(d_uop), .rd(d_rd), .rs1(d_rs1), .rs2(d_rs2),
        .imm(d_imm), .instr_pc(d_instr_pc), .valid(d_valid), .rs1_data(rs1_data),
        .rs2_data(rs2_data), .mepc(mepc), .mie_bit(mie_bit), .irq(irq), .pc(pc),
        .stall(stall), .flush(flush), .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
        .trap_take(trap_take), .mret_take(mret_take), .interrupt_ack(interrupt_ack),
        .paddr(paddr), .pwdata(pwdata), .pwrite(pwrite), .psel(psel),
        .penable(penable), .prdata(prdata), .pready(pready)
    );

    rv_result u_result (
        .clk(clk), .reset(reset), .rs1(d_rs1), .rs2(d_rs2), .rs1_data(rs1_data),
        .rs2_data(rs2_data), .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
        .trap_take(trap_take), .mret_take(mret_take), .instr_pc(d_instr_pc),
        .mepc(mepc), .mie_bit(mie_bit)
    );

endmodule

`default_nettype wire

//--- rv_result.sv
`default_nettype none

`include "rv_config.svh"

module rv_result (
    input  wire         clk,
    input  wire         reset,
    input  wire  [4:0]  rs1,
    input  wire  [4:0]  rs2,
    output logic [63:0] rs1_data,
    output logic [63:0] rs2_data,
    input  wire         wb_en,
    input  wire  [4:0]  wb_rd,
    input  wire  [63:0] wb_data,
    input  wire         trap_take,
    input  wire         mret_take,
    input  wire  [63:0] instr_pc,
    output logic [63:0] mepc,
    output logic        mie_bit
);

    logic [63:0] regs [`NUM_REGS];  // x0 slot never written
    logic        mpie_bit;

    // Read ports, combinational, x0 hardwired
    assign rs1_data = (rs1 == 5'd0) ? 64'd0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? 64'd0 : regs[rs2];

    // Single write port
    always_ff @(posedge clk) begin
        if (wb_en && (wb_rd != 5'd0)) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // mstatus MIE / MPIE
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mie_bit  <= 1'b1;  // Interrupts on out of reset
            mpie_bit <= 1'b0;
        end else if (trap_take) begin
            mpie_bit <= mie_bit;
            mie_bit  <= 1'b0;  // Handler runs masked
        end else if (mret_take) begin
            mie_bit  <= mpie_bit;
            mpie_bit <= 1'b1;
        end
    end

    // Trap return address
    always_ff @(posedge clk) begin
        if (trap_take) begin
            mepc <= instr_pc;  // Interrupted word reruns after mret
        end
    end

endmodule

`default_nettype wire

//--- rv_execute.sv
`default_nettype none

`include "rv_config.svh"

module rv_execute (
    input  wire                clk,
    input  wire                reset,
    input  wire rv_core_pkg::uop_t uop,
    input  wire         [4:0]  rd,
    input  wire         [4:0]  rs1,
    input  wire         [4:0]  rs2,
    input  wire         [63:0] imm,
    input  wire         [63:0] instr_pc,
    input  wire                valid,
    input  wire         [63:0] rs1_data,
    input  wire         [63:0] rs2_data,
    input  wire         [63:0] mepc,
    input  wire                mie_bit,
    input  wire                irq,
    output logic        [63:0] pc,
    output logic               stall,
    output logic               flush,
    output logic               wb_en,
    output logic        [4:0]  wb_rd,
    output logic        [63:0] wb_data,
    output logic               trap_take,
    output logic               mret_take,
    output logic               interrupt_ack,
    output logic        [63:0] paddr,
    output logic        [63:0] pwdata,
    output logic               pwrite,
    output logic               psel,
    output logic               penable,
    input  wire         [63:0] prdata,
    input  wire                pready
);

    rv_core_pkg::apb_state_t state;

    logic jal_take;
    logic mem_op;     // LD or SD in the instruction register
    logic mem_start;  // Open a transfer this cycle
    logic mem_done;   // Last access cycle
    logic [63:0] pc_next;

    // Interrupt only between bus transfers, never on a bubble
    assign trap_take = irq && mie_bit && valid && (state == rv_core_pkg::APB_IDLE);
    assign jal_take  = !trap_take && (uop == rv_core_pkg::UOP_JAL);
    assign mret_take = !trap_take && (uop == rv_core_pkg::UOP_MRET);

    assign mem_op    = (uop == rv_core_pkg::UOP_LD) || (uop == rv_core_pkg::UOP_SD);
    assign mem_start = mem_op && !trap_take && (state == rv_core_pkg::APB_IDLE);
    assign mem_done  = (state == rv_core_pkg::APB_ACCESS) && pready;

    assign stall         = mem_op && !trap_take && !mem_done;  // Freeze fetch and IR
    assign flush         = trap_take || jal_take || mret_take;
    assign interrupt_ack = trap_take;  // One cycle, IR is a bubble next

    // Next pc, trap first
    always_comb begin
        if (trap_take) begin
            pc_next = `TRAP_VECTOR;
        end else if (jal_take) begin
            pc_next = instr_pc + imm;
        end else if (mret_take) begin
            pc_next = mepc;
        end else if (stall) begin
            pc_next = pc;  // Keep presenting the word after LD/SD
        end else begin
            pc_next = pc + 64'd4;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc <= `RAM_BASE;
        end else begin
            pc <= pc_next;
        end
    end

    // Write-back request, committed by the register file at the edge
    always_comb begin
        wb_en   = 1'b0;
        wb_rd   = rd;
        wb_data = '0;
        if (!trap_take) begin
            case (uop)
                rv_core_pkg::UOP_LUI: begin
                    wb_en   = 1'b1;
                    wb_data = imm;
                end
                rv_core_pkg::UOP_ADDI: begin
                    wb_en   = 1'b1;
                    wb_data = rs1_data + imm;
                end
                rv_core_pkg::UOP_JAL: begin
                    wb_en   = 1'b1;
                    wb_data = instr_pc + 64'd4;  // Link address
                end
                rv_core_pkg::UOP_LD: begin
                    wb_en   = mem_done;  // Data valid with pready
                    wb_data = prdata;
                end
                default: wb_en = 1'b0;
            endcase
        end
    end

    // APB requester
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state   <= rv_core_pkg::APB_IDLE;
            psel    <= 1'b0;
            penable <= 1'b0;
            pwrite  <= 1'b0;
        end else begin
            case (state)
                rv_core_pkg::APB_IDLE: begin
                    if (mem_start) begin
                        psel   <= 1'b1;
                        pwrite <= (uop == rv_core_pkg::UOP_SD);
                        state  <= rv_core_pkg::APB_SETUP;
                    end
                end
                rv_core_pkg::APB_SETUP: begin
                    penable <= 1'b1;
                    state   <= rv_core_pkg::APB_ACCESS;
                end
                rv_core_pkg::APB_ACCESS: begin
                    if (pready) begin  // Wait states just loop here
                        psel    <= 1'b0;
                        penable <= 1'b0;
                        state   <= rv_core_pkg::APB_IDLE;
                    end
                end
                default: state <= rv_core_pkg::APB_IDLE;
            endcase
        end
    end

    // Address and data latched once, stable for the transfer
    always_ff @(posedge clk) begin
        if (mem_start) begin
            paddr  <= rs1_data + imm;
            pwdata <= rs2_data;
        end
    end

endmodule

`default_nettype wire

//--- rv_decode.sv
`default_nettype none

module rv_decode (
    input  wire                clk,
    input  wire                reset,
    input  wire         [31:0] instruction,  // Word at pc, same cycle
    input  wire         [63:0] pc,
    input  wire                stall,
    input  wire                flush,
    output rv_core_pkg::uop_t  uop,
    output logic        [4:0]  rd,
    output logic        [4:0]  rs1,
    output logic        [4:0]  rs2,
    output logic        [63:0] imm,
    output logic        [63:0] instr_pc,
    output logic               valid
);

    localparam logic [2:0] F3_ADD = 3'b000;  // addi

    rv_isa_pkg::instr_t ir;       // Instruction register
    rv_core_pkg::uop_t  dec_uop;  // Decode before bubble masking

    // Valid bit, the only control state here
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            valid <= 1'b0;  // Start with a bubble
        end else if (flush) begin
            valid <= 1'b0;  // Squash the word fetched behind a transfer
        end else if (!stall) begin
            valid <= 1'b1;
        end
    end

    // Word and its address, held while a bus transfer runs
    always_ff @(posedge clk) begin
        if (!stall) begin
            ir       <= instruction;
            instr_pc <= pc;
        end
    end

    // Register fields sit at fixed positions in every format
    assign rd  = ir.i_view.rd;
    assign rs1 = ir.i_view.rs1;
    assign rs2 = ir.s_view.rs2;

    always_comb begin
        dec_uop = rv_core_pkg::UOP_NOP;
        imm     = '0;
        case (ir.i_view.opcode)
            rv_isa_pkg::OP_LUI: begin
                dec_uop = rv_core_pkg::UOP_LUI;
                imm     = {{32{ir[31]}}, ir[31:12], 12'h000};  // U-type
            end
            rv_isa_pkg::OP_IMM: begin
                if (ir.i_view.funct3 == F3_ADD) begin
                    dec_uop = rv_core_pkg::UOP_ADDI;
                end
                imm = {{52{ir.i_view.imm[11]}}, ir.i_view.imm};
            end
            rv_isa_pkg::OP_JAL: begin
                dec_uop = rv_core_pkg::UOP_JAL;
                // J-type, scrambled 20-bit offset in halfwords
                imm = {{44{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
            end
            rv_isa_pkg::OP_LOAD: begin
                if (ir.i_view.funct3 == rv_isa_pkg::F3_DOUBLE) begin
                    dec_uop = rv_core_pkg::UOP_LD;
                end
                imm = {{52{ir.i_view.imm[11]}}, ir.i_view.imm};
            end
            rv_isa_pkg::OP_STORE: begin
                if (ir.s_view.funct3 == rv_isa_pkg::F3_DOUBLE) begin
                    dec_uop = rv_core_pkg::UOP_SD;
                end
                imm = {{52{ir.s_view.imm_hi[6]}}, ir.s_view.imm_hi, ir.s_view.imm_lo};
            end
            rv_isa_pkg::OP_SYSTEM: begin
                if (ir == rv_isa_pkg::MRET_WORD) begin
                    dec_uop = rv_core_pkg::UOP_MRET;  // No CSR ops, only mret
                end
            end
            default: dec_uop = rv_core_pkg::UOP_NOP;  // Retires as no-op
        endcase
    end

    // Bubble looks like a no-op downstream
    assign uop = valid ? dec_uop : rv_core_pkg::UOP_NOP;

endmodule

`default_nettype wire

//--- rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

    // Decoded operation held with the instruction register
    typedef enum logic [2:0] {
        UOP_NOP,    // Bubble or unknown encoding
        UOP_LUI,
        UOP_ADDI,
        UOP_JAL,
        UOP_LD,
        UOP_SD,
        UOP_MRET
    } uop_t;

    // Data side bus requester
    typedef enum logic [1:0] {
        APB_IDLE,   // No transfer open
        APB_SETUP,  // psel high, penable low
        APB_ACCESS  // penable high, waiting on pready
    } apb_state_t;

endpackage

`default_nettype wire

//--- rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // Base opcodes, bits 6:0
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    localparam logic [2:0] F3_DOUBLE = 3'b011;  // LD / SD width

    // mret: funct12 0x302, all other fields zero
    localparam logic [31:0] MRET_WORD = 32'h3020_0073;

    // Interrupt flag in bit 63, cause 11 is machine external
    localparam logic [63:0] MCAUSE_MEI = 64'h8000_0000_0000_000B;

    // I-type layout, also used for U/J/R register fields
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    // S-type layout, immediate split around rs2/rs1
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_view_t;

    typedef union packed {
        i_view_t i_view;
        s_view_t s_view;
    } instr_t;

endpackage

`default_nettype wire

//--- rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Reset pc, start of instruction RAM
`define RAM_BASE    64'h0000_0000_8000_0000

// Fixed mtvec, direct mode
`define TRAP_VECTOR 64'h0000_0000_8000_0800

// Integer register file depth
`define NUM_REGS    32

`endif
